// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_AUIPC  = 7'b001_0111,
        OPC_STORE  = 7'b010_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111
    } opcode_e;

    localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000; // SUB, SRA

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_instr_u;

endpackage : rv_isa_pkg

// File: logic/ex_stage_pkg.sv
package ex_stage_pkg;
    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        ALU_ADDR   = 2'b00,
        ALU_BRANCH = 2'b01,
        ALU_OP     = 2'b10
    } alu_class_e;

    typedef struct packed {
        alu_class_e cls;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } alu_ctrl_t;

    typedef struct packed {
        rv_instr_u   instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } issue_t;

    typedef struct packed {
        logic a_is_pc;
        logic b_is_imm;
        logic a_is_zero; // LUI
    } opsel_t;

    typedef struct packed {
        logic        valid;
        logic        wr_en;
        logic [4:0]  rd;
        logic [31:0] result;
    } wb_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage : ex_stage_pkg

// File: logic/ex_control.sv
module ex_control
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_valid,
    input  issue_t      i_issue,
    input  logic [31:0] i_alu_result,
    input  logic        i_alu_zero,
    input  logic [31:0] i_link,
    input  logic [31:0] i_target,
    output issue_t      o_issue_q,
    output alu_ctrl_t   o_alu_ctrl,
    output opsel_t      o_opsel,
    output logic        o_is_branch,
    output logic        o_is_jump,
    output wb_t         o_wb,
    output redirect_t   o_redirect
);

    logic        valid_q;
    issue_t      issue_q;
    logic        wr_en_d;
    logic        taken_d;
    logic        wb_valid_q;
    logic        wb_wr_en_q;
    logic        taken_q;
    logic [4:0]  rd_q;
    logic [31:0] result_q;
    logic [31:0] target_q;

    // Stage 1 registers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            issue_q <= i_issue;
        end
    end

    always_comb begin
        o_alu_ctrl  = '{cls: ALU_ADDR, funct3: 3'b000, funct7: FUNCT7_BASE};
        o_opsel     = '0;
        o_is_branch = 1'b0;
        o_is_jump   = 1'b0;
        wr_en_d     = 1'b0;
        case (issue_q.instr.r.opcode)
            OPC_OP: begin
                o_alu_ctrl = '{cls: ALU_OP, funct3: issue_q.instr.r.funct3,
                               funct7: issue_q.instr.r.funct7};
                wr_en_d    = 1'b1;
            end
            OPC_OP_IMM: begin
                o_alu_ctrl.cls    = ALU_OP;
                o_alu_ctrl.funct3 = issue_q.instr.i.funct3;
                // Only shifts carry a real funct7 in the immediate
                if (issue_q.instr.i.funct3 == F3_SLL || issue_q.instr.i.funct3 == F3_SRL_SRA) begin
                    o_alu_ctrl.funct7 = issue_q.instr.r.funct7;
                end
                o_opsel.b_is_imm = 1'b1;
                wr_en_d          = 1'b1;
            end
            OPC_LUI: begin
                o_opsel.a_is_zero = 1'b1;
                o_opsel.b_is_imm  = 1'b1;
                wr_en_d           = 1'b1;
            end
            OPC_AUIPC: begin
                o_opsel.a_is_pc  = 1'b1;
                o_opsel.b_is_imm = 1'b1;
                wr_en_d          = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                o_is_jump = 1'b1;
                wr_en_d   = 1'b1; // Link value
            end
            OPC_BRANCH: begin
                o_alu_ctrl.cls    = ALU_BRANCH;
                o_alu_ctrl.funct3 = issue_q.instr.b.funct3;
                o_is_branch       = 1'b1;
            end
            OPC_LOAD, OPC_STORE: begin
                o_opsel.b_is_imm = 1'b1; // Address only
            end
            default: ;
        endcase
    end

    assign taken_d = o_is_jump | (o_is_branch & i_alu_zero);

    // Stage 2 registers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wb_valid_q <= 1'b0;
            wb_wr_en_q <= 1'b0;
            taken_q    <= 1'b0;
            target_q   <= '0;
        end else begin
            wb_valid_q <= valid_q;
            wb_wr_en_q <= valid_q & wr_en_d;
            taken_q    <= valid_q & taken_d;
            if (valid_q) begin
                target_q <= i_target;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (valid_q) begin
            rd_q     <= issue_q.instr.r.rd;
            result_q <= o_is_jump ? i_link : i_alu_result;
        end
    end

    assign o_issue_q  = issue_q;
    assign o_wb       = '{valid: wb_valid_q, wr_en: wb_wr_en_q, rd: rd_q, result: result_q};
    assign o_redirect = '{taken: taken_q, target: target_q};

endmodule : ex_control

// File: logic/ex_operand_select.sv
module ex_operand_select
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;
(
    input  issue_t      i_issue,
    input  opsel_t      i_opsel,
    output logic [31:0] o_a,
    output logic [31:0] o_b,
    output logic [31:0] o_imm
);

    rv_instr_u instr;

    assign instr = i_issue.instr;

    // Immediate by format
    always_comb begin
        case (instr.r.opcode)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: begin
                o_imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            OPC_STORE: begin
                o_imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            OPC_BRANCH: begin
                o_imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                         instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                o_imm = {instr.u.imm_31_12, 12'b0};
            end
            OPC_JAL: begin
                o_imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                         instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

    always_comb begin
        if (i_opsel.a_is_zero) begin
            o_a = '0;
        end else if (i_opsel.a_is_pc) begin
            o_a = i_issue.pc;
        end else begin
            o_a = i_issue.rs1;
        end
    end

    assign o_b = i_opsel.b_is_imm ? o_imm : i_issue.rs2;

endmodule : ex_operand_select

// File: logic/ex_alu.sv
module ex_alu
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;
(
    input  logic [31:0] i_a,
    input  logic [31:0] i_b,
    input  alu_ctrl_t   i_ctrl_alu,
    output logic [31:0] o_result,
    output logic        o_zero
);

    logic cond;

    always_comb begin
        o_result = '0;
        cond     = 1'b0;
        case (i_ctrl_alu.cls)
            ALU_ADDR: begin
                o_result = i_a + i_b;
            end
            ALU_BRANCH: begin
                case (i_ctrl_alu.funct3)
                    F3_BEQ:  cond = (i_a == i_b);
                    F3_BNE:  cond = (i_a != i_b);
                    F3_BLT:  cond = ($signed(i_a) < $signed(i_b));
                    F3_BGE:  cond = ($signed(i_a) >= $signed(i_b));
                    F3_BLTU: cond = (i_a < i_b);
                    F3_BGEU: cond = (i_a >= i_b);
                    default: cond = 1'b0;
                endcase
                o_result = i_a - i_b;
            end
            ALU_OP: begin
                case (i_ctrl_alu.funct3)
                    F3_ADD_SUB: begin
                        case (i_ctrl_alu.funct7)
                            FUNCT7_BASE: o_result = i_a + i_b;
                            FUNCT7_ALT:  o_result = i_a - i_b;
                            default:     o_result = '0;
                        endcase
                    end
                    F3_SLL:  o_result = i_a << i_b[4:0];
                    F3_SLT:  o_result = {31'b0, $signed(i_a) < $signed(i_b)};
                    F3_SLTU: o_result = {31'b0, i_a < i_b};
                    F3_XOR:  o_result = i_a ^ i_b;
                    F3_SRL_SRA: begin
                        case (i_ctrl_alu.funct7)
                            FUNCT7_BASE: o_result = i_a >> i_b[4:0];
                            FUNCT7_ALT:  o_result = $signed(i_a) >>> i_b[4:0];
                            default:     o_result = '0;
                        endcase
                    end
                    F3_OR:   o_result = i_a | i_b;
                    F3_AND:  o_result = i_a & i_b;
                    default: o_result = '0;
                endcase
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

    // Branch condition, else zero result
    assign o_zero = (i_ctrl_alu.cls == ALU_BRANCH) ? cond : (o_result == '0);

endmodule : ex_alu

// File: logic/ex_branch_unit.sv
module ex_branch_unit
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;
(
    input  issue_t      i_issue,
    input  logic [31:0] i_imm,
    input  logic        i_is_jump,
    input  logic        i_is_branch,
    output logic [31:0] o_target,
    output logic [31:0] o_link
);

    logic        is_jalr;
    logic [31:0] base;
    logic [31:0] sum;

    assign is_jalr = i_is_jump && (i_issue.instr.r.opcode == OPC_JALR);
    assign base    = is_jalr ? i_issue.rs1 : i_issue.pc;
    assign sum     = base + i_imm;
    assign o_link  = i_issue.pc + 32'd4;

    always_comb begin
        if (is_jalr) begin
            o_target = {sum[31:1], 1'b0}; // JALR clears bit 0
        end else if (i_is_jump || i_is_branch) begin
            o_target = sum;
        end else begin
            o_target = o_link; // Sequential
        end
    end

endmodule : ex_branch_unit

// File: logic/ex_top.sv
module ex_top
    import ex_stage_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_valid,
    input  issue_t    i_issue,
    output wb_t       o_wb,
    output redirect_t o_redirect
);

    issue_t      issue_q;
    alu_ctrl_t   alu_ctrl;
    opsel_t      opsel;
    logic        is_branch;
    logic        is_jump;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] imm;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] target;
    logic [31:0] link;

    ex_control control_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_issue      (i_issue),
        .i_alu_result (alu_result),
        .i_alu_zero   (alu_zero),
        .i_link       (link),
        .i_target     (target),
        .o_issue_q    (issue_q),
        .o_alu_ctrl   (alu_ctrl),
        .o_opsel      (opsel),
        .o_is_branch  (is_branch),
        .o_is_jump    (is_jump),
        .o_wb         (o_wb),
        .o_redirect   (o_redirect)
    );

    ex_operand_select operand_select_i (
        .i_issue (issue_q),
        .i_opsel (opsel),
        .o_a     (op_a),
        .o_b     (op_b),
        .o_imm   (imm)
    );

    ex_alu alu_i (
        .i_a        (op_a),
        .i_b        (op_b),
        .i_ctrl_alu (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (alu_zero)
    );

    ex_branch_unit branch_unit_i (
        .i_issue     (issue_q),
        .i_imm       (imm),
        .i_is_jump   (is_jump),
        .i_is_branch (is_branch),
        .o_target    (target),
        .o_link      (link)
    );

endmodule : ex_top

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk; // 40 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (5) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule : tb_clock_gen

// File: verification/ex_top_properties.sv
module ex_top_properties
    import ex_stage_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst,
    input logic      i_valid,
    input wb_t       i_wb,
    input redirect_t i_redirect
);
    timeunit 1ns;
    timeprecision 1ps;

    valid_latency: assert property (@(posedge i_clk)
        (!$past(i_rst, 1) && !$past(i_rst, 2)) |-> (i_wb.valid == $past(i_valid, 2)))
        else $error("o_wb.valid does not follow i_valid from two cycles earlier");

    idle_slot_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_wb.valid |-> (!i_wb.wr_en && !i_redirect.taken))
        else $error("wr_en or taken high in an invalid slot");

    reset_clears: assert property (@(posedge i_clk)
        $fell(i_rst) |-> (!i_wb.valid && !i_wb.wr_en && !i_redirect.taken))
        else $error("valid, wr_en or taken high right after reset");

    target_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_redirect.target[0] == 1'b0)
        else $error("redirect target is not halfword aligned");

endmodule : ex_top_properties

bind ex_top ex_top_properties properties_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_wb       (o_wb),
    .i_redirect (o_redirect)
);

// File: verification/tb_ex_top.sv
module tb_ex_top
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;

    typedef struct packed {
        logic        wr_en;
        logic [4:0]  rd;
        logic        chk_result;
        logic [31:0] result;
        logic        taken;
        logic [31:0] target;
    } expect_t;

    logic      clk;
    logic      rst;
    logic      valid;
    issue_t    issue;
    wb_t       wb;
    redirect_t redirect;
    int        errors;
    int        checks;
    int        tests;

    tb_clock_gen clock_gen_i (
        .o_clk (clk),
        .o_rst (rst)
    );

    ex_top dut_i (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_valid    (valid),
        .i_issue    (issue),
        .o_wb       (wb),
        .o_redirect (redirect)
    );

    // Instruction word builders, rs1 = x1 and rs2 = x2
    function automatic logic [31:0] r_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                           logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_word(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [4:0] pick_rd();
        return 5'($urandom_range(31, 1));
    endfunction

    // Shifts keep their funct7 in the upper immediate bits
    function automatic logic [11:0] op_imm_bits(logic [2:0] f3, logic alt);
        if (f3 == 3'b001)
            return {FUNCT7_BASE, 5'($urandom())};
        if (f3 == 3'b101)
            return {alt ? FUNCT7_ALT : FUNCT7_BASE, 5'($urandom())};
        return 12'($urandom());
    endfunction

    function automatic issue_t make_issue(logic [31:0] word, logic [31:0] rs1, logic [31:0] rs2);
        issue_t iss;
        iss.instr = word;
        iss.pc    = $urandom() & 32'hFFFF_FFFC;
        iss.rs1   = rs1;
        iss.rs2   = rs2;
        return iss;
    endfunction

    function automatic issue_t random_instr();
        logic [4:0] rd;
        logic [2:0] f3;
        logic       alt;
        rd  = pick_rd();
        f3  = 3'($urandom());
        alt = $urandom_range(1, 0) && (f3 == 3'b000 || f3 == 3'b101);
        case ($urandom_range(7, 0))
            0: return make_issue(r_word(alt ? FUNCT7_ALT : FUNCT7_BASE, f3, rd),
                                 $urandom(), $urandom());
            1: return make_issue(i_word(op_imm_bits(f3, alt), f3, rd, OPC_OP_IMM),
                                 $urandom(), 32'h0);
            2: return make_issue(u_word(20'($urandom()), rd, OPC_LUI), $urandom(), 32'h0);
            3: return make_issue(u_word(20'($urandom()), rd, OPC_AUIPC), $urandom(), 32'h0);
            4: return make_issue(j_word(21'($urandom()) & 21'h1F_FFFE, rd), 32'h0, 32'h0);
            5: return make_issue(i_word(12'($urandom()), 3'b000, rd, OPC_JALR), $urandom(), 32'h0);
            6: return make_issue(b_word(13'($urandom()) & 13'h1FFE, (f3[2:1] == 2'b01) ? 3'b000 : f3),
                                 $urandom(), $urandom());
            default: return make_issue(f3[0] ? s_word(12'($urandom()))
                                             : i_word(12'($urandom()), 3'b010, rd, OPC_LOAD),
                                       $urandom(), $urandom());
        endcase
    endfunction

    // RV32I integer computation
    function automatic logic [31:0] alu_result_of(logic [2:0] f3, logic alt, logic [31:0] a,
                                                  logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken_of(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic expect_t expected_for(issue_t iss);
        expect_t     e;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        w     = iss.instr;
        f3    = w[14:12];
        rd    = w[11:7];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e     = '0;
        case (w[6:0])
            OPC_OP:     e = '{1'b1, rd, 1'b1,
                              alu_result_of(f3, w[30], iss.rs1, iss.rs2), 1'b0, 32'h0};
            OPC_OP_IMM: e = '{1'b1, rd, 1'b1,
                              alu_result_of(f3, (f3 == 3'b101) && w[30], iss.rs1, imm_i),
                              1'b0, 32'h0};
            OPC_LUI:    e = '{1'b1, rd, 1'b1, imm_u, 1'b0, 32'h0};
            OPC_AUIPC:  e = '{1'b1, rd, 1'b1, iss.pc + imm_u, 1'b0, 32'h0};
            OPC_JAL:    e = '{1'b1, rd, 1'b1, iss.pc + 32'd4, 1'b1, iss.pc + imm_j};
            OPC_JALR:   e = '{1'b1, rd, 1'b1, iss.pc + 32'd4, 1'b1,
                              (iss.rs1 + imm_i) & ~32'h1};
            OPC_BRANCH: e = '{1'b0, rd, 1'b0, 32'h0,
                              branch_taken_of(f3, iss.rs1, iss.rs2), iss.pc + imm_b};
            OPC_LOAD:   e = '{1'b0, rd, 1'b1, iss.rs1 + imm_i, 1'b0, 32'h0};
            OPC_STORE:  e = '{1'b0, rd, 1'b1, iss.rs1 + imm_s, 1'b0, 32'h0};
            default: ; // Unsupported, nothing written or taken
        endcase
        return e;
    endfunction

    task automatic expect_equal(input string name, input string field,
                                input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs(input string name, input int latency, input expect_t e);
        expect_equal(name, "latency", 32'd2, latency);
        expect_equal(name, "wr_en", e.wr_en, wb.wr_en);
        if (e.wr_en)
            expect_equal(name, "rd", e.rd, wb.rd);
        if (e.chk_result)
            expect_equal(name, "result", e.result, wb.result);
        expect_equal(name, "taken", e.taken, redirect.taken);
        if (e.taken)
            expect_equal(name, "target", e.target, redirect.target);
    endtask

    // Starts and ends on a falling edge, one instruction per rising edge
    task automatic play_sequence(input string name, input issue_t seq[$]);
        expect_t exp_q[$];
        int      got;
        int      n;
        foreach (seq[k])
            exp_q.push_back(expected_for(seq[k]));
        fork
            begin
                foreach (seq[k]) begin
                    @(posedge clk);
                    valid <= 1'b1;
                    issue <= seq[k];
                end
                @(posedge clk);
                valid <= 1'b0;
            end
            begin
                got = 0;
                n   = 0;
                while (got < exp_q.size() && n < exp_q.size() + TIMEOUT_CYCLES) begin
                    @(negedge clk);
                    n++;
                    if (wb.valid) begin
                        compare_outputs(name, n - (got + 1), exp_q[got]);
                        got++;
                    end
                end
                if (got < exp_q.size()) begin
                    $display("%s: timed out waiting for result %0d of %0d", name, got + 1,
                             exp_q.size());
                    errors++;
                end
            end
        join
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("%-24s %s (%0d errors)", name, (errors == err_start) ? "passed" : "failed",
                 errors - err_start);
    endtask

    task automatic reset_idle();
        int err_start;
        err_start = errors;
        repeat (4) begin
            @(negedge clk);
            expect_equal("reset_idle", "valid", 32'd0, wb.valid);
            expect_equal("reset_idle", "wr_en", 32'd0, wb.wr_en);
            expect_equal("reset_idle", "taken", 32'd0, redirect.taken);
        end
        report_test("reset_idle", err_start);
    endtask

    task automatic alu_arith();
        issue_t seq[$];
        int     err_start;
        int     f;
        err_start = errors;
        repeat (3) begin
            for (f = 0; f < 8; f++) begin
                seq.push_back(make_issue(r_word(FUNCT7_BASE, 3'(f), pick_rd()),
                                         $urandom(), $urandom()));
                seq.push_back(make_issue(i_word(op_imm_bits(3'(f), 1'b0), 3'(f), pick_rd(),
                                                OPC_OP_IMM), $urandom(), 32'h0));
                if (f == 0 || f == 5)
                    seq.push_back(make_issue(r_word(FUNCT7_ALT, 3'(f), pick_rd()),
                                             $urandom(), $urandom()));
            end
            seq.push_back(make_issue(i_word(op_imm_bits(3'b101, 1'b1), 3'b101, pick_rd(),
                                            OPC_OP_IMM), $urandom(), 32'h0)); // SRAI
            // ADDI whose upper immediate looks like the SUB funct7
            seq.push_back(make_issue(i_word({FUNCT7_ALT, 5'($urandom())}, 3'b000, pick_rd(),
                                            OPC_OP_IMM), $urandom(), 32'h0));
        end
        play_sequence("alu_arith", seq);
        report_test("alu_arith", err_start);
    endtask

    task automatic branch_conditions();
        issue_t      seq[$];
        logic [31:0] pair_a[4];
        logic [31:0] pair_b[4];
        logic [31:0] a;
        logic [31:0] b;
        int          err_start;
        int          f;
        int          p;
        err_start = errors;
        pair_a    = '{32'h1234_5678, 32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF};
        pair_b    = '{32'h1234_5678, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000};
        for (f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            for (p = 0; p < 7; p++) begin
                a = (p < 3) ? $urandom() : pair_a[p - 3];
                b = (p < 3) ? $urandom() : pair_b[p - 3];
                seq.push_back(make_issue(b_word(13'($urandom()) & 13'h1FFE, 3'(f)), a, b));
            end
        end
        play_sequence("branch_conditions", seq);
        report_test("branch_conditions", err_start);
    endtask

    task automatic jumps_and_upper();
        issue_t seq[$];
        int     err_start;
        err_start = errors;
        repeat (4) begin
            seq.push_back(make_issue(j_word(21'($urandom()) & 21'h1F_FFFE, pick_rd()),
                                     32'h0, 32'h0));
            seq.push_back(make_issue(i_word(12'($urandom()), 3'b000, pick_rd(), OPC_JALR),
                                     $urandom(), 32'h0));
            seq.push_back(make_issue(u_word(20'($urandom()), pick_rd(), OPC_LUI),
                                     $urandom(), 32'h0));
            seq.push_back(make_issue(u_word(20'($urandom()), pick_rd(), OPC_AUIPC),
                                     $urandom(), 32'h0));
        end
        play_sequence("jumps_and_upper", seq);
        report_test("jumps_and_upper", err_start);
    endtask

    task automatic address_and_unsupported();
        issue_t seq[$];
        int     err_start;
        err_start = errors;
        repeat (4) begin
            seq.push_back(make_issue(i_word(12'($urandom()), 3'b010, pick_rd(), OPC_LOAD),
                                     $urandom(), $urandom()));
            seq.push_back(make_issue(s_word(12'($urandom())), $urandom(), $urandom()));
        end
        seq.push_back(make_issue({25'($urandom()), 7'b111_0011}, $urandom(), $urandom()));
        seq.push_back(make_issue({25'($urandom()), 7'b000_1111}, $urandom(), $urandom()));
        seq.push_back(make_issue({25'($urandom()), 7'b000_1011}, $urandom(), $urandom()));
        play_sequence("address_and_unsupported", seq);
        report_test("address_and_unsupported", err_start);
    endtask

    task automatic back_to_back_burst();
        issue_t seq[$];
        int     err_start;
        err_start = errors;
        repeat (32)
            seq.push_back(random_instr());
        play_sequence("back_to_back_burst", seq);
        report_test("back_to_back_burst", err_start);
    endtask

    initial begin
        int n;
        valid  = 1'b0;
        issue  = '0;
        errors = 0;
        checks = 0;
        tests  = 0;
        void'($urandom(25));
        n = 0;
        while (rst !== 1'b0 && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was still asserted after %0d cycles", n);
            errors++;
        end else begin
            reset_idle();
            alu_arith();
            branch_conditions();
            jumps_and_upper();
            address_and_unsupported();
            back_to_back_burst();
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_ex_top

// File: vlog.f
logic/rv_isa_pkg.sv
logic/ex_stage_pkg.sv
logic/ex_control.sv
logic/ex_operand_select.sv
logic/ex_alu.sv
logic/ex_branch_unit.sv
logic/ex_top.sv
verification/tb_clock_gen.sv
verification/ex_top_properties.sv
verification/tb_ex_top.sv

// File: Bender.yml
package:
  name: rv32_ex_stage

sources:
  - logic/rv_isa_pkg.sv
  - logic/ex_stage_pkg.sv
  - logic/ex_control.sv
  - logic/ex_operand_select.sv
  - logic/ex_alu.sv
  - logic/ex_branch_unit.sv
  - logic/ex_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/ex_top_properties.sv
      - verification/tb_ex_top.sv
